// File: rtl/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;	// Data, address or instruction
	typedef logic [4:0] reg_addr_t;	// Register index

	// R-type layout; low bits also serve as immediate and jump index
	typedef struct packed {
		logic [5:0] op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	typedef enum logic [5:0] {
		op_special = 6'h00,	// Decoded further on funct
		op_j = 6'h02,
		op_jal = 6'h03,
		op_beq = 6'h04,
		op_bne = 6'h05,
		op_addiu = 6'h09,
		op_slti = 6'h0a,
		op_sltiu = 6'h0b,
		op_andi = 6'h0c,
		op_ori = 6'h0d,
		op_xori = 6'h0e,
		op_lui = 6'h0f,
		op_lw = 6'h23,
		op_sw = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_sra = 6'h03,
		fn_sllv = 6'h04,	// Variable shifts take amount from rs
		fn_srlv = 6'h06,
		fn_srav = 6'h07,
		fn_jr = 6'h08,
		fn_jalr = 6'h09,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and = 6'h24,
		fn_or = 6'h25,
		fn_xor = 6'h26,
		fn_slt = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_and, alu_or, alu_xor, alu_add, alu_sub, alu_slt,
		alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} dst_sel_e;	// dst_ra is $31
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_e;	// Link is PC plus 4
	typedef enum logic [1:0] {pc_seq, pc_jump, pc_reg} pc_sel_e;	// Branch folds into pc_seq

	typedef struct packed {
		logic reg_write;
		dst_sel_e dst;
		logic alu_src_imm;	// B operand from immediate
		logic imm_zero_ext;	// Logic immediates and lui
		logic shift_by_reg;
		alu_op_e alu_op;
		logic mem_write;
		logic mem_read;
		wb_sel_e wb;
		logic branch;
		logic branch_ne;
		pc_sel_e pc_sel;
		logic illegal;	// Unknown code, runs as no-op
	} ctrl_t;

	localparam word_t reset_vector = 32'hbfc0_0000;
	localparam word_t halt_address = 32'h0000_0000;	// jr here stops the core
	localparam reg_addr_t v0_index = 5'd2;

endpackage

// File: rtl/mips_alu.sv
module mips_alu (
	input mips_pkg::alu_op_e op,
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	input logic [4:0] shamt,
	output mips_pkg::word_t result,
	output logic equal
);
	import mips_pkg::*;

	word_t sum;
	word_t diff;
	logic lt_signed;
	logic lt_unsigned;

	assign sum = a + b;	// Wraps, no overflow trap
	assign diff = a - b;
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_add: result = sum;
			alu_sub: result = diff;
			alu_slt: result = {31'b0, lt_signed};
			alu_sltu: result = {31'b0, lt_unsigned};
			alu_sll: result = b << shamt;	// Shifts act on b
			alu_srl: result = b >> shamt;
			alu_sra: result = word_t'($signed(b) >>> shamt);	// Sign fills in
			alu_lui: result = {b[15:0], 16'b0};
			default: result = '0;
		endcase
	end

	// Independent of op so branches need no ALU setting
	assign equal = (a == b);

endmodule

// File: rtl/mips_regfile.sv
module mips_regfile (
	input logic clk,
	input logic reset,
	input logic write_enable,
	input mips_pkg::reg_addr_t read_addr_a,
	input mips_pkg::reg_addr_t read_addr_b,
	input mips_pkg::reg_addr_t write_addr,
	input mips_pkg::word_t write_data,
	output mips_pkg::word_t read_data_a,
	output mips_pkg::word_t read_data_b,
	output mips_pkg::word_t v0
);
	import mips_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;	// Whole file cleared
			end
		end else if (write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;	// $zero never written
		end
	end

	assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];
	assign v0 = regs[v0_index];	// Tap for register_v0

endmodule

// File: rtl/mips_control.sv
module mips_control (
	input mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	ctrl_t dec;	// Main decode, alu_op filled in below
	alu_op_e alu_op;

	// Main decoder
	always_comb begin
		dec = '0;
		dec.dst = dst_rt;
		dec.alu_op = alu_add;	// Overridden by ALU decode
		dec.wb = wb_alu;
		dec.pc_sel = pc_seq;
		case (instr.op)
			op_special: begin
				case (instr.funct)
					fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sltu,
					fn_sll, fn_srl, fn_sra: begin
						dec.reg_write = 1'b1;
						dec.dst = dst_rd;
					end
					fn_sllv, fn_srlv, fn_srav: begin
						dec.reg_write = 1'b1;
						dec.dst = dst_rd;
						dec.shift_by_reg = 1'b1;	// Amount from rs
					end
					fn_jr: dec.pc_sel = pc_reg;
					fn_jalr: begin
						dec.reg_write = 1'b1;
						dec.dst = dst_rd;	// Link into rd
						dec.wb = wb_link;
						dec.pc_sel = pc_reg;
					end
					default: dec.illegal = 1'b1;
				endcase
			end
			op_addiu, op_slti, op_sltiu: begin
				dec.reg_write = 1'b1;
				dec.alu_src_imm = 1'b1;	// Sign extended
			end
			op_andi, op_ori, op_xori, op_lui: begin
				dec.reg_write = 1'b1;
				dec.alu_src_imm = 1'b1;
				dec.imm_zero_ext = 1'b1;
			end
			op_lw: begin
				dec.reg_write = 1'b1;
				dec.alu_src_imm = 1'b1;	// Base plus offset
				dec.mem_read = 1'b1;
				dec.wb = wb_mem;
			end
			op_sw: begin
				dec.alu_src_imm = 1'b1;
				dec.mem_write = 1'b1;
			end
			op_beq: dec.branch = 1'b1;	// Equal flag compares rs, rt
			op_bne: begin
				dec.branch = 1'b1;
				dec.branch_ne = 1'b1;
			end
			op_j: dec.pc_sel = pc_jump;
			op_jal: begin
				dec.reg_write = 1'b1;
				dec.dst = dst_ra;
				dec.wb = wb_link;
				dec.pc_sel = pc_jump;
			end
			default: dec.illegal = 1'b1;	// Enables stay low
		endcase
	end

	// ALU decoder
	always_comb begin
		alu_op = alu_add;	// Loads, stores, addiu, jumps
		case (instr.op)
			op_special: begin
				case (instr.funct)
					fn_subu: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or: alu_op = alu_or;
					fn_xor: alu_op = alu_xor;
					fn_slt: alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll, fn_sllv: alu_op = alu_sll;
					fn_srl, fn_srlv: alu_op = alu_srl;
					fn_sra, fn_srav: alu_op = alu_sra;
					default: alu_op = alu_add;	// addu and jumps
				endcase
			end
			op_beq, op_bne: alu_op = alu_sub;
			op_slti: alu_op = alu_slt;
			op_sltiu: alu_op = alu_sltu;
			op_andi: alu_op = alu_and;
			op_ori: alu_op = alu_or;
			op_xori: alu_op = alu_xor;
			op_lui: alu_op = alu_lui;
			default: alu_op = alu_add;
		endcase
	end

	always_comb begin
		ctrl = dec;
		ctrl.alu_op = alu_op;
	end

endmodule

// File: rtl/mips_datapath.sv
module mips_datapath (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	input mips_pkg::ctrl_t ctrl,
	input mips_pkg::instr_t instr,
	input mips_pkg::word_t data_readdata,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t data_address,
	output mips_pkg::word_t data_writedata,
	output logic data_write,
	output logic data_read,
	output logic active,
	output mips_pkg::word_t register_v0
);
	import mips_pkg::*;

	logic step;	// Instruction retires at next edge
	logic halt;
	logic branch_taken;
	logic equal;
	logic [15:0] imm;
	logic [4:0] shamt;
	word_t imm_sext;
	word_t imm_zext;
	word_t pc_plus4;
	word_t pc_branch;
	word_t pc_jump_target;
	word_t pc_next;
	word_t rs_data;
	word_t rt_data;
	word_t alu_b;
	word_t alu_result;
	word_t wb_data;
	reg_addr_t wb_addr;

	assign step = clk_enable & active;

	// Immediate forms
	assign imm = {instr.rd, instr.shamt, instr.funct};
	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'b0, imm};

	// Next PC
	assign pc_plus4 = pc + 32'd4;
	assign pc_branch = pc_plus4 + {imm_sext[29:0], 2'b00};
	assign pc_jump_target = {pc_plus4[31:28], instr.rs, instr.rt, imm, 2'b00};	// 26-bit index
	assign branch_taken = ctrl.branch & (ctrl.branch_ne ? ~equal : equal);

	always_comb begin
		case (ctrl.pc_sel)
			pc_jump: pc_next = pc_jump_target;
			pc_reg: pc_next = rs_data;	// jr, jalr
			default: pc_next = branch_taken ? pc_branch : pc_plus4;
		endcase
	end

	assign halt = (ctrl.pc_sel == pc_reg) && (rs_data == halt_address);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= reset_vector;
			active <= 1'b1;
		end else if (step) begin
			pc <= pc_next;	// Holds once inactive
			if (halt) begin
				active <= 1'b0;	// Falls on the retiring edge
			end
		end
	end

	// ALU operands
	assign alu_b = !ctrl.alu_src_imm ? rt_data : (ctrl.imm_zero_ext ? imm_zext : imm_sext);
	assign shamt = ctrl.shift_by_reg ? rs_data[4:0] : instr.shamt;

	// Write-back
	always_comb begin
		case (ctrl.dst)
			dst_rd: wb_addr = instr.rd;
			dst_ra: wb_addr = 5'd31;
			default: wb_addr = instr.rt;
		endcase
		case (ctrl.wb)
			wb_mem: wb_data = data_readdata;
			wb_link: wb_data = pc_plus4;	// No delay slot
			default: wb_data = alu_result;
		endcase
	end

	mips_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.write_enable(ctrl.reg_write & step),
		.read_addr_a(instr.rs),
		.read_addr_b(instr.rt),
		.write_addr(wb_addr),
		.write_data(wb_data),
		.read_data_a(rs_data),
		.read_data_b(rt_data),
		.v0(register_v0)
	);

	mips_alu u_alu (
		.op(ctrl.alu_op),
		.a(rs_data),
		.b(alu_b),
		.shamt(shamt),
		.result(alu_result),
		.equal(equal)
	);

	assign data_address = alu_result;	// Base plus offset
	assign data_writedata = rt_data;
	assign data_write = ctrl.mem_write & step;	// Low while stalled or halted
	assign data_read = ctrl.mem_read & step;

endmodule

// File: rtl/mips_cpu_harvard.sv
module mips_cpu_harvard (
	input logic clk,
	input logic reset,
	output logic active,
	output mips_pkg::word_t register_v0,

	input logic clk_enable,	// Low stalls the core

	output mips_pkg::word_t instr_address,
	input mips_pkg::word_t instr_readdata,	// Same-cycle answer

	output mips_pkg::word_t data_address,
	output logic data_write,
	output logic data_read,
	output mips_pkg::word_t data_writedata,
	input mips_pkg::word_t data_readdata
);
	import mips_pkg::*;

	instr_t instr;
	ctrl_t ctrl;

	assign instr = instr_t'(instr_readdata);	// Fields of fetched word

	mips_control u_control (
		.instr(instr),
		.ctrl(ctrl)
	);

	mips_datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.ctrl(ctrl),
		.instr(instr),
		.data_readdata(data_readdata),
		.pc(instr_address),	// Fetch address is the PC
		.data_address(data_address),
		.data_writedata(data_writedata),
		.data_write(data_write),
		.data_read(data_read),
		.active(active),
		.register_v0(register_v0)
	);

endmodule

// File: sim/tb_mips_tests.svh
task automatic check_idle();
	check_word("instr_address", reset_vector, instr_address);
	check_word("active", 1, active);
	check_word("data_write", 0, data_write);
	check_word("data_read", 0, data_read);
	check_word("register_v0", 0, register_v0);
endtask

task automatic test_reset();
	clear_program();
	emit(encode_r(fn_jr, 0, 0, 0, 0));	// Halt at once
	@(posedge clk);
	#2;
	reset = 1'b1;
	repeat (2) @(posedge clk);
	#2;
	check_idle();	// Mid reset
	repeat (2) @(posedge clk);
	#2;
	reset = 1'b0;
	#1;
	check_idle();	// Released, nothing retired yet
	wait_halt();
	check_word("register_v0", 0, register_v0);
endtask

// Result goes to $11, then out to the next store slot
task automatic emit_result(word_t w, word_t expected);
	emit(w);
	emit(encode_i(op_sw, 10, 11, 16'(4 * expected_q.size())));
	expected_q.push_back(expected);
endtask

task automatic test_arith();
	word_t a;
	word_t b;
	word_t simm;
	word_t zimm;
	word_t sra_fill;
	logic [15:0] imm;
	logic [4:0] sh;
	a = lcg_next();
	b = lcg_next();
	imm = 16'(lcg_next() >> 8);
	sh = 5'(lcg_next() >> 27);
	simm = {{16{imm[15]}}, imm};
	zimm = {16'h0, imm};
	sra_fill = {32{b[31]}} & ~(32'hffff_ffff >> sh);	// Copies of the sign in vacated top bits
	clear_program();
	load_const(8, a);
	load_const(9, b);
	load_const(10, data_base);
	emit_result(encode_r(fn_addu, 8, 9, 11, 0), a + b);
	emit_result(encode_r(fn_subu, 8, 9, 11, 0), a - b);
	emit_result(encode_r(fn_and, 8, 9, 11, 0), a & b);
	emit_result(encode_r(fn_or, 8, 9, 11, 0), a | b);
	emit_result(encode_r(fn_xor, 8, 9, 11, 0), a ^ b);
	emit_result(encode_r(fn_slt, 8, 9, 11, 0), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
	emit_result(encode_r(fn_sltu, 8, 9, 11, 0), (a < b) ? 32'd1 : 32'd0);
	emit_result(encode_i(op_addiu, 8, 11, imm), a + simm);
	emit_result(encode_i(op_andi, 8, 11, imm), a & zimm);	// Logic immediates zero extend
	emit_result(encode_i(op_ori, 8, 11, imm), a | zimm);
	emit_result(encode_i(op_xori, 8, 11, imm), a ^ zimm);
	emit_result(encode_i(op_slti, 8, 11, imm), ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0);
	emit_result(encode_i(op_sltiu, 8, 11, imm), (a < simm) ? 32'd1 : 32'd0);	// Sext, then unsigned
	emit_result(encode_i(op_lui, 0, 11, imm), {imm, 16'h0});
	emit_result(encode_r(fn_sll, 0, 9, 11, sh), b << sh);
	emit_result(encode_r(fn_srl, 0, 9, 11, sh), b >> sh);
	emit_result(encode_r(fn_sra, 0, 9, 11, sh), (b >> sh) | sra_fill);
	emit(encode_r(fn_jr, 0, 0, 0, 0));
	reset_core();
	wait_halt();
	check_stores();
endtask

task automatic test_load_store();
	word_t d [3];
	for (int i = 0; i < 3; i++) begin
		d[i] = lcg_next();
		dmem[i] = d[i];	// Preload first words of data region
	end
	clear_program();
	load_const(10, data_base);
	emit(encode_i(op_lw, 10, 2, 0));
	emit(encode_i(op_lw, 10, 12, 4));
	emit(encode_r(fn_addu, 2, 12, 2, 0));
	emit(encode_i(op_lw, 10, 12, 8));
	emit(encode_r(fn_addu, 2, 12, 2, 0));
	emit(encode_r(fn_jr, 0, 0, 0, 0));
	reset_core();
	wait_halt();
	check_word("register_v0", d[0] + d[1] + d[2], register_v0);
	check_true(saw_read, "data_read was never asserted during the loads");
endtask

task automatic test_branches();
	word_t x;
	word_t expected;
	x = lcg_next();
	clear_program();
	load_const(8, x);
	load_const(9, x);
	load_const(13, x ^ 32'h1);	// Differs from $8 in bit 0
	emit(encode_i(op_beq, 8, 9, 1));	// Offset 1 skips the next add
	emit(encode_i(op_addiu, 2, 2, 1));
	emit(encode_i(op_beq, 8, 13, 1));
	emit(encode_i(op_addiu, 2, 2, 2));
	emit(encode_i(op_bne, 8, 13, 1));
	emit(encode_i(op_addiu, 2, 2, 4));
	emit(encode_i(op_bne, 8, 9, 1));
	emit(encode_i(op_addiu, 2, 2, 8));
	emit(encode_r(fn_jr, 0, 0, 0, 0));
	// Each add runs only when the branch before it falls through
	expected = ((x == x) ? 32'd0 : 32'd1) + ((x == (x ^ 32'h1)) ? 32'd0 : 32'd2)
		+ ((x != (x ^ 32'h1)) ? 32'd0 : 32'd4) + ((x != x) ? 32'd0 : 32'd8);
	reset_core();
	wait_halt();
	check_word("register_v0", expected, register_v0);
endtask

task automatic test_jumps();
	logic [15:0] imm;
	imm = 16'(lcg_next()) & 16'h3fff;
	clear_program();
	load_const(10, data_base);	// Words 0 and 1
	emit(encode_j(op_j, reset_vector + 16));
	emit(encode_i(op_addiu, 2, 2, 16'h4000));	// Skipped by j
	emit(encode_j(op_jal, reset_vector + 28));
	emit(encode_i(op_sw, 10, 31, 0));	// Link register out
	emit(encode_r(fn_jr, 0, 0, 0, 0));
	emit(encode_i(op_addiu, 2, 2, imm));	// Subroutine
	emit(encode_r(fn_jr, 31, 0, 0, 0));
	expected_q.push_back(reset_vector + 20);	// jal at word 4, plus 4
	reset_core();
	wait_halt();
	check_word("register_v0", {16'h0, imm}, register_v0);
	check_stores();
	check_word("instr_address", halt_address, instr_address);
	repeat (5) begin
		@(posedge clk);
		#2;
		check_word("instr_address", halt_address, instr_address);	// PC frozen
		check_word("active", 0, active);
	end
endtask

task automatic test_stall();
	word_t a;
	word_t v0_expected;
	word_t held;
	a = lcg_next();
	v0_expected = a + a + 32'd5;	// Double, then add 5
	clear_program();
	load_const(8, a);
	load_const(10, data_base);
	emit(encode_r(fn_addu, 8, 8, 2, 0));
	emit(encode_i(op_sw, 10, 2, 0));
	emit(encode_i(op_addiu, 2, 2, 5));
	emit(encode_i(op_sw, 10, 2, 4));
	emit(encode_r(fn_jr, 0, 0, 0, 0));
	expected_q.push_back(a + a);
	expected_q.push_back(v0_expected);
	reset_core();
	wait_halt();
	check_word("register_v0", v0_expected, register_v0);	// Unstalled run
	check_stores();
	reset_core();
	repeat (5) @(posedge clk);
	#2;
	clk_enable = 1'b0;	// First sw is being decoded
	held = reset_vector + 32'd20;	// Word 5 holds the first sw
	check_word("instr_address", held, instr_address);
	repeat (6) begin
		@(posedge clk);
		#2;
		check_word("instr_address", held, instr_address);
		check_word("data_write", 0, data_write);
	end
	check_word("store count", 0, store_addr.size());
	clk_enable = 1'b1;
	wait_halt();
	check_word("register_v0", v0_expected, register_v0);
	check_stores();
endtask

// File: sim/tb_mips_cpu_harvard.sv
module tb_mips_cpu_harvard;
	import mips_pkg::*;

	localparam int halt_limit = 200;	// Cycles allowed per run
	localparam int watchdog_time = 6 * 300 * 20;	// Tests x cycles x period
	localparam word_t data_base = 32'h0000_1000;	// Base of data region

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	logic data_write;
	logic data_read;
	logic saw_read;	// data_read seen at an edge
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	word_t data_writedata;
	word_t data_readdata;
	word_t imem_offset;
	word_t rng_state;
	word_t imem [256];	// Word 0 sits at reset_vector
	word_t dmem [256];
	word_t store_addr [$];	// Every recorded store
	word_t store_data [$];
	word_t expected_q [$];	// Expected store values, one per word from data_base
	int prog_len;
	int value_errors;
	int other_errors;

	mips_cpu_harvard u_mips_cpu_harvard (
		.clk(clk),
		.reset(reset),
		.active(active),
		.register_v0(register_v0),
		.clk_enable(clk_enable),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

	always #10 clk = ~clk;

	// Memories answer in the same cycle
	assign imem_offset = instr_address - reset_vector;
	assign instr_readdata = (imem_offset < 32'd1024) ? imem[imem_offset[9:2]] : '0;	// Nop outside
	assign data_readdata = dmem[data_address[9:2]];

	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_address[9:2]] <= data_writedata;
			store_addr.push_back(data_address);
			store_data.push_back(data_writedata);
		end
		if (data_read) begin
			saw_read = 1'b1;
		end
	end

	function automatic word_t lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;	// Numerical Recipes constants
		return rng_state;
	endfunction

	function automatic word_t encode_r(funct_e fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t encode_i(opcode_e op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_j(opcode_e op, word_t target);
		return {op, target[27:2]};	// Upper bits come from the PC
	endfunction

	task automatic emit(word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_const(reg_addr_t r, word_t v);
		emit(encode_i(op_lui, 0, r, v[31:16]));
		emit(encode_i(op_ori, r, r, v[15:0]));
	endtask

	task automatic clear_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		prog_len = 0;
		expected_q.delete();
	endtask

	task automatic reset_core();
		@(posedge clk);
		#2;
		reset = 1'b1;
		store_addr.delete();
		store_data.delete();
		saw_read = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	task automatic check_word(string name, word_t expected, word_t actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_true(logic cond, string what);
		assert (cond) else begin
			other_errors++;
			$display("ERROR at %0t: %s", $time, what);
		end
	endtask

	task automatic wait_halt();
		int cycles;
		cycles = 0;
		while (active && cycles < halt_limit) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		check_true(!active, "core did not halt within the cycle limit");
	endtask

	task automatic check_stores();
		check_word("store count", expected_q.size(), store_addr.size());
		for (int i = 0; i < store_addr.size() && i < expected_q.size(); i++) begin
			check_word("data_address", data_base + 4 * i, store_addr[i]);
			check_word("data_writedata", expected_q[i], store_data[i]);
		end
	endtask

	`include "tb_mips_tests.svh"

	initial begin
		#(watchdog_time);
		$display("Watchdog expired after %0d time units, the core stopped making progress",
			watchdog_time);
		$display("Test failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		clk_enable = 1'b1;
		saw_read = 1'b0;
		rng_state = 32'hfd8a_94fb;
		value_errors = 0;
		other_errors = 0;
		clear_program();
		for (int i = 0; i < 256; i++) begin
			dmem[i] = (data_base + 4 * i) ^ 32'h5a5a_a5a5;	// Pattern over full address
		end
		test_reset();
		test_arith();
		test_load_store();
		test_branches();
		test_jumps();
		test_stall();
		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: mips_harvard.f
+incdir+sim
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_regfile.sv
rtl/mips_control.sv
rtl/mips_datapath.sv
rtl/mips_cpu_harvard.sv
sim/tb_mips_cpu_harvard.sv

// File: Bender.yml
package:
  name: mips_harvard

sources:
  - rtl/mips_pkg.sv
  - rtl/mips_alu.sv
  - rtl/mips_regfile.sv
  - rtl/mips_control.sv
  - rtl/mips_datapath.sv
  - rtl/mips_cpu_harvard.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mips_cpu_harvard.sv
